/* rtl/cpuPkg.sv */
package cpuPkg;

    typedef logic [7:0]  data_t;
    typedef logic [7:0]  addr_t;
    typedef logic [15:0] instr_t;
    typedef logic [1:0]  regIdx_t;
    typedef logic [3:0]  flags_t;

    localparam int FLAG_Z = 3;
    localparam int FLAG_C = 2;
    localparam int FLAG_N = 1;
    localparam int FLAG_O = 0;

    localparam int MEM_DEPTH = 256;
    localparam int NUM_REGS  = 4;

    // Instruction fields
    localparam int OPC_HI   = 15;
    localparam int OPC_LO   = 12;
    localparam int MODE_BIT = 10;  // LD immediate when set
    localparam int DST_HI   = 9;
    localparam int DST_LO   = 8;
    localparam int SRC1_HI  = 5;
    localparam int SRC1_LO  = 4;
    localparam int SRC2_HI  = 1;
    localparam int SRC2_LO  = 0;
    localparam int IMM_HI   = 7;
    localparam int IMM_LO   = 0;

    typedef enum logic [3:0] {
        opAnd, opOr, opNot, opAdd, opSub, opLsr, opLsl, opInc,
        opDec, opBra, opBne, opMov, opLd, opSt, opNopE, opNopF
    } opcode_t;

    typedef enum logic [2:0] {
        passA, andOp, orOp, notA, addOp, subOp, lsrOp, lslOp
    } aluOp_t;

    typedef enum logic [1:0] {regClear, regLoad, regDec, regInc} regFun_t;

    typedef enum logic [1:0] {srcAlu, srcMem, srcImm} wrSrc_t;

    typedef enum logic [1:0] {fetchHi, fetchLo, exec} phase_t;

endpackage

/* rtl/rfCtrlIf.sv */
`timescale 1ns/1ps

interface rfCtrlIf import cpuPkg::*; ();

    logic    wrEn;
    regFun_t fun;
    regIdx_t dst;
    regIdx_t srcA;
    regIdx_t srcB;
    wrSrc_t  wrSrc;

    modport ctrl (output wrEn, fun, dst, srcA, srcB, wrSrc);

    modport rf (input wrEn, fun, dst, srcA, srcB, wrSrc);

endinterface

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic  CLK,
    input  logic  rstN_i,
    rfCtrlIf.rf   ctl,
    input  data_t aluRes_i,
    input  data_t memData_i,
    input  data_t imm_i,
    output data_t opA_o,
    output data_t opB_o
);

    data_t regs [NUM_REGS];
    data_t loadData;

    always_comb begin
        case (ctl.wrSrc)
            srcMem:  loadData = memData_i;
            srcImm:  loadData = imm_i;
            default: loadData = aluRes_i;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!rstN_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctl.wrEn) begin
            case (ctl.fun)
                regClear: regs[ctl.dst] <= '0;
                regLoad:  regs[ctl.dst] <= loadData;
                regDec:   regs[ctl.dst] <= regs[ctl.dst] - 8'd1;
                regInc:   regs[ctl.dst] <= regs[ctl.dst] + 8'd1;
            endcase
        end
    end

    assign opA_o = regs[ctl.srcA];
    assign opB_o = regs[ctl.srcB];

    // Decode from the control unit must be clean on a write
    assert property (@(posedge CLK) disable iff (!rstN_i)
        ctl.wrEn |-> !$isunknown({ctl.dst, ctl.fun, ctl.wrSrc}));

endmodule

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  logic   CLK,
    input  logic   rstN_i,
    input  aluOp_t op_i,
    input  data_t  a_i,
    input  data_t  b_i,
    input  logic   flagWe_i,
    output data_t  result_o,
    output flags_t flags_o
);

    logic [8:0] sum;
    logic [8:0] diff;
    data_t      res;
    flags_t     flagReg;
    flags_t     nextFlags;

    assign sum  = {1'b0, a_i} + {1'b0, b_i};
    assign diff = {1'b0, a_i} - {1'b0, b_i};  // Bit 8 set when a < b

    always_comb begin
        nextFlags = flagReg;
        case (op_i)
            andOp: res = a_i & b_i;
            orOp:  res = a_i | b_i;
            notA:  res = ~a_i;
            addOp: begin
                res = sum[7:0];
                nextFlags[FLAG_C] = sum[8];
                nextFlags[FLAG_O] = (a_i[7] == b_i[7]) && (res[7] != a_i[7]);
            end
            subOp: begin
                res = diff[7:0];
                nextFlags[FLAG_C] = diff[8];
                nextFlags[FLAG_O] = (a_i[7] != b_i[7]) && (res[7] != a_i[7]);
            end
            lsrOp: begin
                res = a_i >> 1;
                nextFlags[FLAG_C] = a_i[0];  // Bit shifted out
            end
            lslOp: begin
                res = a_i << 1;
                nextFlags[FLAG_C] = a_i[7];
            end
            default: res = a_i;
        endcase
        // Z and N follow every operation
        nextFlags[FLAG_Z] = (res == '0);
        nextFlags[FLAG_N] = res[7];
    end

    always_ff @(posedge CLK) begin
        if (!rstN_i) begin
            flagReg <= '0;
        end else if (flagWe_i) begin
            flagReg <= nextFlags;
        end
    end

    assign result_o = res;
    assign flags_o  = flagReg;

    assert property (@(posedge CLK) rstN_i |-> !$isunknown(flags_o));

endmodule

/* rtl/addrUnit.sv */
`timescale 1ns/1ps

module addrUnit import cpuPkg::*; (
    input  logic  CLK,
    input  logic  rstN_i,
    input  logic  pcInc_i,
    input  logic  pcLoad_i,
    input  logic  addrSel_i,
    input  addr_t target_i,
    output addr_t memAddr_o
);

    addr_t pc;

    always_ff @(posedge CLK) begin
        if (!rstN_i) begin
            pc <= '0;
        end else if (pcLoad_i) begin
            pc <= target_i;  // Taken branch
        end else if (pcInc_i) begin
            pc <= pc + 8'd1;
        end
    end

    // Operand address in exec, PC while fetching
    assign memAddr_o = addrSel_i ? target_i : pc;

    assert property (@(posedge CLK) disable iff (!rstN_i) !(pcInc_i && pcLoad_i));

endmodule

/* rtl/dataMem.sv */
`timescale 1ns/1ps

module dataMem import cpuPkg::*; (
    input  logic  CLK,
    input  logic  rstN_i,
    input  logic  we_i,
    input  addr_t addr_i,
    input  data_t wData_i,
    input  logic  progWe_i,
    input  addr_t progAddr_i,
    input  data_t progData_i,
    output data_t rData_o
);

    data_t mem [MEM_DEPTH];

    always_ff @(posedge CLK) begin
        if (!rstN_i) begin
            // Program load only while the core is held
            if (progWe_i) begin
                mem[progAddr_i] <= progData_i;
            end
        end else if (we_i) begin
            mem[addr_i] <= wData_i;
        end
    end

    assign rData_o = mem[addr_i];

endmodule

/* rtl/ctrlUnit.sv */
`timescale 1ns/1ps

module ctrlUnit import cpuPkg::*; (
    input  logic   CLK,
    input  logic   rstN_i,
    input  data_t  memData_i,
    input  flags_t flags_i,
    rfCtrlIf.ctrl  rfCtrl,
    output data_t  imm_o,
    output aluOp_t aluOp_o,
    output logic   flagWe_o,
    output logic   pcInc_o,
    output logic   pcLoad_o,
    output logic   addrSel_o,
    output logic   memWe_o,
    output logic   instrDone_o
);

    phase_t  phase;
    instr_t  ir;
    opcode_t opc;

    always_ff @(posedge CLK) begin
        if (!rstN_i) begin
            phase <= fetchHi;
        end else begin
            case (phase)
                fetchHi: phase <= fetchLo;
                fetchLo: phase <= exec;
                default: phase <= fetchHi;
            endcase
        end
    end

    // Instruction register fills high byte first
    always_ff @(posedge CLK) begin
        if (phase == fetchHi) begin
            ir[OPC_HI:IMM_HI+1] <= memData_i;
        end
        if (phase == fetchLo) begin
            ir[IMM_HI:IMM_LO] <= memData_i;
        end
    end

    assign opc         = opcode_t'(ir[OPC_HI:OPC_LO]);
    assign imm_o       = ir[IMM_HI:IMM_LO];
    assign instrDone_o = (phase == exec);
    assign pcInc_o     = (phase != exec);

    always_comb begin
        rfCtrl.wrEn  = 1'b0;
        rfCtrl.fun   = regLoad;
        rfCtrl.dst   = ir[DST_HI:DST_LO];
        rfCtrl.srcA  = ir[SRC1_HI:SRC1_LO];
        rfCtrl.srcB  = ir[SRC2_HI:SRC2_LO];
        rfCtrl.wrSrc = srcAlu;
        aluOp_o      = passA;
        flagWe_o     = 1'b0;
        pcLoad_o     = 1'b0;
        addrSel_o    = 1'b0;
        memWe_o      = 1'b0;
        if (phase == exec) begin
            case (opc)
                opAnd, opOr, opNot, opAdd, opSub, opLsr, opLsl, opMov: begin
                    rfCtrl.wrEn = 1'b1;
                    flagWe_o    = 1'b1;
                    case (opc)
                        opAnd:   aluOp_o = andOp;
                        opOr:    aluOp_o = orOp;
                        opNot:   aluOp_o = notA;
                        opAdd:   aluOp_o = addOp;
                        opSub:   aluOp_o = subOp;
                        opLsr:   aluOp_o = lsrOp;
                        opLsl:   aluOp_o = lslOp;
                        default: aluOp_o = passA;  // MOV
                    endcase
                end
                opInc, opDec: begin
                    rfCtrl.wrEn = 1'b1;
                    rfCtrl.fun  = (opc == opInc) ? regInc : regDec;
                end
                opLd: begin
                    rfCtrl.wrEn  = 1'b1;
                    rfCtrl.wrSrc = ir[MODE_BIT] ? srcImm : srcMem;
                    addrSel_o    = 1'b1;
                end
                opSt: begin
                    rfCtrl.srcB = ir[DST_HI:DST_LO];  // Store data on port B
                    addrSel_o   = 1'b1;
                    memWe_o     = 1'b1;
                end
                opBra: pcLoad_o = 1'b1;
                opBne: pcLoad_o = !flags_i[FLAG_Z];
                default: ;  // E and F do nothing
            endcase
        end
    end

    // Every exec follows a fetchLo
    assert property (@(posedge CLK) disable iff (!rstN_i)
        instrDone_o |-> $past(phase) == fetchLo);

    assert property (@(posedge CLK) disable iff (!rstN_i)
        memWe_o |-> instrDone_o && addrSel_o);

endmodule

/* rtl/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
    input  logic   CLK,
    input  logic   rstN_i,
    input  logic   progWe_i,
    input  addr_t  progAddr_i,
    input  data_t  progData_i,
    output logic   memWe_o,
    output addr_t  memAddr_o,
    output data_t  memWData_o,
    output flags_t flags_o,
    output logic   instrDone_o
);

    data_t  memData;
    data_t  imm;
    data_t  opA;
    data_t  aluRes;
    aluOp_t aluOp;
    logic   flagWe;
    logic   pcInc;
    logic   pcLoad;
    logic   addrSel;

    rfCtrlIf rfCtrl ();

    ctrlUnit uCtrl (
        .CLK         (CLK),
        .rstN_i      (rstN_i),
        .memData_i   (memData),
        .flags_i     (flags_o),
        .rfCtrl      (rfCtrl.ctrl),
        .imm_o       (imm),
        .aluOp_o     (aluOp),
        .flagWe_o    (flagWe),
        .pcInc_o     (pcInc),
        .pcLoad_o    (pcLoad),
        .addrSel_o   (addrSel),
        .memWe_o     (memWe_o),
        .instrDone_o (instrDone_o)
    );

    regFile uRegFile (
        .CLK       (CLK),
        .rstN_i    (rstN_i),
        .ctl       (rfCtrl.rf),
        .aluRes_i  (aluRes),
        .memData_i (memData),
        .imm_i     (imm),
        .opA_o     (opA),
        .opB_o     (memWData_o)  // Also the store data
    );

    alu uAlu (
        .CLK      (CLK),
        .rstN_i   (rstN_i),
        .op_i     (aluOp),
        .a_i      (opA),
        .b_i      (memWData_o),
        .flagWe_i (flagWe),
        .result_o (aluRes),
        .flags_o  (flags_o)
    );

    addrUnit uAddr (
        .CLK       (CLK),
        .rstN_i    (rstN_i),
        .pcInc_i   (pcInc),
        .pcLoad_i  (pcLoad),
        .addrSel_i (addrSel),
        .target_i  (imm),
        .memAddr_o (memAddr_o)
    );

    dataMem uMem (
        .CLK        (CLK),
        .rstN_i     (rstN_i),
        .we_i       (memWe_o),
        .addr_i     (memAddr_o),
        .wData_i    (memWData_o),
        .progWe_i   (progWe_i),
        .progAddr_i (progAddr_i),
        .progData_i (progData_i),
        .rData_o    (memData)
    );

endmodule

/* tests/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Instruction-set model run alongside the DUT
data_t  progImage [MEM_DEPTH];
data_t  modelMem  [MEM_DEPTH];
data_t  modelRegs [NUM_REGS];
addr_t  modelPc;
flags_t modelFlags;

// 63 random instructions, a jump back to 0x00, then random data
task automatic genProgram();
    logic [31:0] rnd;
    opcode_t     opc;
    data_t       hi;
    data_t       lo;
    data_t       tgt;
    for (int i = 0; i < 63; i++) begin
        rnd = xorshift();
        opc = opcode_t'(rnd[15:12]);
        hi  = rnd[15:8];
        lo  = rnd[7:0];
        case (opc)
            opLd, opSt: lo[7] = 1'b1;  // Data area only
            opBra, opBne: begin
                tgt = rnd[23:16] % 8'd63;
                lo  = {tgt[6:0], 1'b0};  // Even, below 0x7E
            end
            default: ;
        endcase
        progImage[2 * i]     = hi;
        progImage[2 * i + 1] = lo;
    end
    progImage[126] = {opBra, 4'h0};
    progImage[127] = 8'h00;
    for (int i = 128; i < MEM_DEPTH; i++) begin
        rnd          = xorshift();
        progImage[i] = rnd[7:0];
    end
    for (int i = 0; i < MEM_DEPTH; i++) begin
        modelMem[i] = progImage[i];
    end
    for (int i = 0; i < NUM_REGS; i++) begin
        modelRegs[i] = '0;
    end
    modelPc    = '0;
    modelFlags = '0;
endtask

// One instruction; reports whether it stored, and where and what
task automatic stepModel(output logic isSt, output addr_t stAddr, output data_t stData);
    instr_t  ins;
    opcode_t opc;
    regIdx_t d;
    data_t   a;
    data_t   b;
    data_t   r;
    data_t   imm;
    int      sRes;
    logic    aluDone;
    ins     = {modelMem[modelPc], modelMem[modelPc + 8'd1]};
    opc     = opcode_t'(ins[15:12]);
    d       = ins[9:8];
    a       = modelRegs[ins[5:4]];
    b       = modelRegs[ins[1:0]];
    imm     = ins[7:0];
    r       = a;
    aluDone = 1'b0;
    isSt    = 1'b0;
    stAddr  = imm;
    stData  = modelRegs[d];
    modelPc = modelPc + 8'd2;
    case (opc)
        opAnd: begin
            r       = a & b;
            aluDone = 1'b1;
        end
        opOr: begin
            r       = a | b;
            aluDone = 1'b1;
        end
        opNot: begin
            r       = ~a;
            aluDone = 1'b1;
        end
        opMov: begin
            r       = a;
            aluDone = 1'b1;
        end
        opAdd: begin
            r = a + b;
            modelFlags[FLAG_C] = (int'(a) + int'(b)) > 255;
            sRes = int'($signed(a)) + int'($signed(b));
            modelFlags[FLAG_O] = (sRes > 127) || (sRes < -128);
            aluDone = 1'b1;
        end
        opSub: begin
            r = a - b;
            modelFlags[FLAG_C] = a < b;  // Borrow
            sRes = int'($signed(a)) - int'($signed(b));
            modelFlags[FLAG_O] = (sRes > 127) || (sRes < -128);
            aluDone = 1'b1;
        end
        opLsr: begin
            r = {1'b0, a[7:1]};
            modelFlags[FLAG_C] = a[0];
            aluDone = 1'b1;
        end
        opLsl: begin
            r = {a[6:0], 1'b0};
            modelFlags[FLAG_C] = a[7];
            aluDone = 1'b1;
        end
        opInc: modelRegs[d] = modelRegs[d] + 8'd1;
        opDec: modelRegs[d] = modelRegs[d] - 8'd1;
        opLd:  modelRegs[d] = ins[10] ? imm : modelMem[imm];
        opSt: begin
            isSt           = 1'b1;
            modelMem[imm]  = stData;
        end
        opBra: modelPc = imm;
        opBne: begin
            if (!modelFlags[FLAG_Z]) begin
                modelPc = imm;
            end
        end
        default: ;  // NOP
    endcase
    if (aluDone) begin
        modelRegs[d]       = r;
        modelFlags[FLAG_Z] = (r == 8'h00);
        modelFlags[FLAG_N] = r[7];
    end
endtask

`endif

/* tests/tbCpu.sv */
`timescale 1ns/1ps

module tbCpu import cpuPkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int RESET_CYC   = 5;
    localparam int NUM_INSTR   = 400;
    localparam int LIMIT_CYC   = MEM_DEPTH + 1 + RESET_CYC + NUM_INSTR * 3 + 50;

    logic   CLK;
    logic   rstN_i;
    logic   progWe_i;
    addr_t  progAddr_i;
    data_t  progData_i;
    logic   memWe_o;
    addr_t  memAddr_o;
    data_t  memWData_o;
    flags_t flags_o;
    logic   instrDone_o;

    logic [31:0] rngState = 32'd23;
    int byteErrs   = 0;
    int addrErrs   = 0;
    int flagErrs   = 0;
    int strobeErrs = 0;
    int numStores  = 0;

    cpuTop u_dut (
        .CLK         (CLK),
        .rstN_i      (rstN_i),
        .progWe_i    (progWe_i),
        .progAddr_i  (progAddr_i),
        .progData_i  (progData_i),
        .memWe_o     (memWe_o),
        .memAddr_o   (memAddr_o),
        .memWData_o  (memWData_o),
        .flags_o     (flags_o),
        .instrDone_o (instrDone_o)
    );

    initial CLK = 1'b0;
    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic logic [31:0] xorshift();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    `include "cpuModel.svh"

    task automatic checkByte(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got 0x%02h, expected 0x%02h", $time, name, got, exp);
            byteErrs++;
        end
    endtask

    task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got 0x%02h, expected 0x%02h", $time, name, got, exp);
            addrErrs++;
        end
    endtask

    task automatic checkFlags(input string name, input flags_t got, input flags_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %b, expected %b (ZCNO)", $time, name, got, exp);
            flagErrs++;
        end
    endtask

    task automatic checkStrobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
            strobeErrs++;
        end
    endtask

    initial begin
        logic  isSt;
        addr_t stAddr;
        data_t stData;
        rstN_i     = 1'b0;
        progWe_i   = 1'b0;
        progAddr_i = '0;
        progData_i = '0;
        genProgram();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            @(posedge CLK);
            progWe_i   <= 1'b1;
            progAddr_i <= addr_t'(i);
            progData_i <= progImage[i];
        end
        @(posedge CLK);
        progWe_i <= 1'b0;
        repeat (RESET_CYC) @(posedge CLK);
        rstN_i <= 1'b1;
        // Sample each of fetchHi, fetchLo and exec mid-cycle
        for (int n = 0; n < NUM_INSTR; n++) begin
            @(negedge CLK);
            checkFlags("flags_o", flags_o, modelFlags);
            checkStrobe("instrDone_o", instrDone_o, 1'b0);
            checkStrobe("memWe_o", memWe_o, 1'b0);
            @(negedge CLK);
            checkStrobe("instrDone_o", instrDone_o, 1'b0);
            checkStrobe("memWe_o", memWe_o, 1'b0);
            @(negedge CLK);
            stepModel(isSt, stAddr, stData);
            checkStrobe("instrDone_o", instrDone_o, 1'b1);
            checkStrobe("memWe_o", memWe_o, isSt);
            if (isSt) begin
                checkAddr("memAddr_o", memAddr_o, stAddr);
                checkByte("memWData_o", memWData_o, stData);
                numStores++;
            end
        end
        @(negedge CLK);
        checkFlags("flags_o", flags_o, modelFlags);
        $display("%0d instructions, %0d stores; errors byte=%0d addr=%0d flags=%0d strobe=%0d",
                 NUM_INSTR, numStores, byteErrs, addrErrs, flagErrs, strobeErrs);
        if (byteErrs + addrErrs + flagErrs + strobeErrs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Load, reset and all instructions plus some slack
    initial begin
        #(LIMIT_CYC * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYC);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tinyCpu8.f */
+incdir+tests
rtl/cpuPkg.sv
rtl/rfCtrlIf.sv
rtl/regFile.sv
rtl/alu.sv
rtl/addrUnit.sv
rtl/dataMem.sv
rtl/ctrlUnit.sv
rtl/cpuTop.sv
tests/tbCpu.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tbCpu -f tinyCpu8.f -o simCpu || exit 1
out=$(./obj_dir/simCpu)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && exit 0 || exit 1
